//--- dv/core_tb.sv
// directed tests only; each instruction waits for its result plus one cycle, kill burst excepted
`timescale 1ns/1ps

module core_tb;
	import core_pkg::*;

	localparam logic [31:0] test_pc = 32'h0000_1000;

	logic        clk;
	logic        arst_n;
	logic        inst_val;
	logic [31:0] inst;
	logic        kill;
	logic        res_val;
	exe_res_t    res;

	int          errors;
	logic [31:0] regs_m [32]; // shadow register file
	logic [31:0] pc_m;        // shadow pc

	// expected result of the instruction in flight
	logic [31:0] exp_data, exp_target, exp_addr, exp_wdata;
	logic [4:0]  exp_rd;
	logic [1:0]  exp_size;
	logic        exp_we, exp_taken, exp_chk_target, exp_mem_req, exp_mem_we, exp_ill;

	core_top #(.reset_pc(test_pc)) dut (
		.clk      (clk),
		.arst_n   (arst_n),
		.inst_val (inst_val),
		.inst     (inst),
		.kill     (kill),
		.res_val  (res_val),
		.res      (res)
	);

	always #10 clk = ~clk;

	// --------------------------------------------------
	// instruction encoders and reference rules
	// --------------------------------------------------
	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, opc_r};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
	endfunction

	function automatic logic [31:0] sext(input logic [31:0] v, input int bits);
		logic signed [31:0] t;
		t = v << (32 - bits);
		return t >>> (32 - bits);
	endfunction

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		logic signed [31:0] sa;
		sa = a;
		case (f3)
			3'd0:    return alt ? a - b : a + b;
			3'd1:    return a << b[4:0]; // shift amount masked to 5 bits
			3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3:    return (a < b) ? 32'd1 : 32'd0;
			3'd4:    return a ^ b;
			3'd5: begin
				if (alt) begin
					return sa >>> b[4:0]; // sign fill
				end
				return a >> b[4:0];
			end
			3'd6:    return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [4:0] pick_reg();
		return 5'(1 + $urandom % 12); // x1..x12 hold random values
	endfunction

	// --------------------------------------------------
	// drive, wait and check
	// --------------------------------------------------
	task automatic clear_exp();
		exp_data       = '0;
		exp_target     = '0;
		exp_addr       = '0;
		exp_wdata      = '0;
		exp_rd         = '0;
		exp_size       = '0;
		exp_we         = 1'b0;
		exp_taken      = 1'b0;
		exp_chk_target = 1'b0;
		exp_mem_req    = 1'b0;
		exp_mem_we     = 1'b0;
		exp_ill        = 1'b0;
	endtask

	task automatic expect_write(input logic [4:0] rd, input logic [31:0] data);
		clear_exp();
		exp_rd   = rd;
		exp_data = data;
		exp_we   = (rd != 5'd0); // x0 is reported with we low
	endtask

	task automatic check_field(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp) else begin
			errors++;
			$display("mismatch %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic issue(input logic [31:0] word);
		@(negedge clk);
		inst_val = 1'b1;
		inst     = word;
		pc_m     = pc_m + 32'd4;
		@(negedge clk);
		inst_val = 1'b0;
	endtask

	task automatic wait_res(output logic ok);
		ok = 1'b0;
		for (int n = 0; n < 10 && !ok; n++) begin
			@(negedge clk);
			ok = res_val;
		end
		assert (ok) else begin
			errors++;
			$display("no result came within 10 cycles of the strobe");
		end
	endtask

	task automatic check_res();
		check_field("res.ill", exp_ill, res.ill);
		check_field("res.we", exp_we, res.we);
		check_field("res.data", exp_data, res.data);
		if (exp_we) begin
			check_field("res.rd", exp_rd, res.rd);
		end
		check_field("res.br_taken", exp_taken, res.br_taken);
		if (exp_chk_target) begin
			check_field("res.target", exp_target, res.target);
		end
		check_field("res.mem_req", exp_mem_req, res.mem_req);
		check_field("res.mem_we", exp_mem_we, res.mem_we);
		if (exp_mem_req) begin
			check_field("res.mem_size", exp_size, res.mem_size);
			check_field("res.mem_addr", exp_addr, res.mem_addr);
			check_field("res.mem_wdata", exp_wdata, res.mem_wdata);
		end
	endtask

	task automatic run(input logic [31:0] word);
		logic ok;
		issue(word);
		wait_res(ok);
		if (ok) begin
			check_res();
		end
		if (exp_we) begin
			regs_m[exp_rd] = exp_data;
		end
	endtask

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------
	task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
		logic [19:0] upper;
		upper = value[31:12] + 20'(value[11]); // undo the addi sign extension
		expect_write(rd, {upper, 12'b0});
		run(enc_u(upper, rd, opc_lui));
		expect_write(rd, regs_m[rd] + sext(32'(value[11:0]), 12));
		run(enc_i(value[11:0], rd, 3'd0, rd, opc_i_r));
	endtask

	task automatic alu_r(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2);
		expect_write(rd, alu_ref(f3, alt, regs_m[rs1], regs_m[rs2]));
		run(enc_r(alt ? f7_alt : f7_base, rs2, rs1, f3, rd));
	endtask

	task automatic alu_i(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		// imm bit 10 selects srai only, there is no subi
		expect_write(rd, alu_ref(f3, (f3 == 3'd5) && imm[10], regs_m[rs1],
			sext(32'(imm), 12)));
		run(enc_i(imm, rs1, f3, rd, opc_i_r));
	endtask

	task automatic branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
		logic [31:0] a, b;
		logic [12:0] imm;
		a   = regs_m[rs1];
		b   = regs_m[rs2];
		imm = {12'($urandom), 1'b0};
		clear_exp();
		case (f3)
			3'd0:    exp_taken = (a == b);
			3'd1:    exp_taken = (a != b);
			3'd4:    exp_taken = ($signed(a) < $signed(b));
			3'd5:    exp_taken = !($signed(a) < $signed(b)); // bge as negated lt
			3'd6:    exp_taken = (a < b);
			default: exp_taken = !(a < b);
		endcase
		exp_chk_target = 1'b1;
		exp_target     = pc_m + sext(32'(imm), 13);
		run(enc_b(imm, rs2, rs1, f3));
	endtask

	task automatic mem_op(input logic store, input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2);
		logic [11:0] imm;
		imm = 12'($urandom);
		clear_exp();
		exp_mem_req = 1'b1;
		exp_mem_we  = store;
		exp_size    = f3[1:0];
		exp_addr    = regs_m[rs1] + sext(32'(imm), 12);
		exp_wdata   = store ? regs_m[rs2] : 32'd0;
		if (store) begin
			run(enc_s(imm, rs2, rs1, f3));
		end else begin
			run(enc_i(imm, rs1, f3, 5'd25, opc_load)); // rd given but never written
		end
	endtask

	task automatic kill_burst();
		int seen;
		seen = 0;
		@(negedge clk);
		inst_val = 1'b1;
		inst     = enc_i(12'd11, 5'd0, 3'd0, 5'd5, opc_i_r);
		@(negedge clk);
		inst = enc_i(12'd22, 5'd0, 3'd0, 5'd6, opc_i_r);
		@(negedge clk);
		inst = enc_i(12'd33, 5'd0, 3'd0, 5'd7, opc_i_r);
		kill = 1'b1; // shares the edge with the third strobe
		@(negedge clk);
		inst_val = 1'b0;
		kill     = 1'b0;
		pc_m     = pc_m + 32'd12; // killed strobes still advance the pc
		for (int n = 0; n < 8; n++) begin
			if (res_val) begin
				seen++;
				if (seen == 1) begin
					check_field("res.rd", 32'd5, res.rd);
					check_field("res.data", 32'd11, res.data);
				end
			end
			@(negedge clk);
		end
		check_field("res_val count", 32'd1, seen);
		regs_m[5] = 32'd11;
	endtask

	initial begin
		clk      = 1'b0;
		arst_n   = 1'b0;
		inst_val = 1'b0;
		inst     = '0;
		kill     = 1'b0;
		errors   = 0;
		pc_m     = test_pc;
		void'($urandom(32115));
		for (int k = 0; k < 32; k++) begin
			regs_m[k] = '0;
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		check_field("res_val", 32'd0, res_val);

		// register loading, x0 included
		for (int r = 1; r <= 12; r++) begin
			load_reg(5'(r), $urandom);
		end
		load_reg(5'd0, $urandom);
		load_reg(5'd13, 32'hffff_fff0);
		load_reg(5'd14, 32'd5);
		load_reg(5'd15, regs_m[1]); // equal pair for branches

		// alu, r-type then i-type
		for (int f = 0; f < 8; f++) begin
			alu_r(3'(f), 1'b0, 5'(20 + f), pick_reg(), pick_reg());
		end
		alu_r(3'd0, 1'b1, 5'd28, pick_reg(), pick_reg());
		alu_r(3'd5, 1'b1, 5'd29, pick_reg(), pick_reg());
		for (int f = 0; f < 8; f++) begin
			if (f == 1 || f == 5) begin
				alu_i(3'(f), 5'(20 + f), pick_reg(), {7'h00, 5'($urandom)});
			end else begin
				alu_i(3'(f), 5'(20 + f), pick_reg(), 12'($urandom));
			end
		end
		alu_i(3'd5, 5'd28, pick_reg(), {7'h20, 5'($urandom)});
		alu_i(3'd2, 5'd29, 5'd14, 12'hffd); // slti 5 < -3
		alu_i(3'd3, 5'd30, 5'd14, 12'hffd); // sltiu with huge unsigned imm
		alu_i(3'd2, 5'd31, 5'd13, 12'hfff);

		// branches on equal, lt and gt pairs
		for (int f = 0; f < 8; f++) begin
			if (f != 2 && f != 3) begin
				branch(3'(f), 5'd1, 5'd15);
				branch(3'(f), 5'd13, 5'd14);
				branch(3'(f), 5'd14, 5'd13);
			end
		end

		// jumps and auipc
		expect_write(5'd16, pc_m + 32'd4);
		exp_taken      = 1'b1;
		exp_chk_target = 1'b1;
		exp_target     = pc_m + sext(32'({20'($urandom), 1'b0}) & 32'h001f_fffe, 21);
		run(enc_j(exp_target[20:0] - pc_m[20:0], 5'd16));
		expect_write(5'd17, pc_m + 32'd4);
		exp_taken      = 1'b1;
		exp_chk_target = 1'b1;
		exp_target     = (regs_m[14] + 32'd2) & ~32'd1; // odd sum, bit 0 dropped
		run(enc_i(12'd2, 5'd14, 3'd0, 5'd17, opc_jalr));
		expect_write(5'd18, pc_m + 32'h000a_5000);
		run(enc_u(20'h000a5, 5'd18, opc_auipc));

		// loads and stores by size
		for (int f = 0; f < 6; f++) begin
			if (f != 3) begin
				mem_op(1'b0, 3'(f), pick_reg(), 5'd0);
			end
			if (f < 3) begin
				mem_op(1'b1, 3'(f), pick_reg(), pick_reg());
			end
		end

		// unknown opcode, then the kill burst
		clear_exp();
		exp_ill = 1'b1;
		run({25'($urandom), 7'b0001011});
		kill_burst();
		alu_r(3'd0, 1'b0, 5'd8, 5'd6, 5'd0); // x6 untouched by its killed write
		expect_write(5'd9, pc_m + 32'h0000_3000);
		run(enc_u(20'h00003, 5'd9, opc_auipc));

		$display("error count %0d", errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- src/core_dec_s.sv
// operands are read with no hazard check; a dependent instruction must trail by 3 cycles
`timescale 1ns/1ps

module core_dec_s (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 fetch_val,
	input  core_pkg::fetch_pkt_t fetch_pkt,
	input  logic                 kill,
	input  core_pkg::wb_t        wb,
	output logic                 dec_val,
	output core_pkg::dec_pkt_t   dec_pkt
);
	import core_pkg::*;

	inst_u           inst;
	dec_pkt_t        dec_d;
	logic [xlen-1:0] src1, src2;
	logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

	// sub and sra only with funct7 alt; i-type checks funct7 on shifts only
	function automatic logic alu_ok(input logic [2:0] f3, input logic [6:0] f7,
		input logic imm);
		logic alt_ok;
		alt_ok = (f3 == f3_srl) || (f3 == f3_add && !imm);
		if (imm && f3 != f3_sll && f3 != f3_srl) begin
			return 1'b1;
		end
		return (f7 == f7_base) || (f7 == f7_alt && alt_ok);
	endfunction

	function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt, input logic imm);
		case (f3)
			f3_add:  return (alt && !imm) ? alu_sub : alu_add; // no subi
			f3_sll:  return alu_sll;
			f3_slt:  return alu_slt;
			f3_sltu: return alu_sltu;
			f3_xor:  return alu_xor;
			f3_srl:  return alt ? alu_sra : alu_srl;
			f3_or:   return alu_or;
			default: return alu_and;
		endcase
	endfunction

	assign inst = fetch_pkt.inst;

	core_reg_file u_reg_file (
		.clk    (clk),
		.arst_n (arst_n),
		.rs1    (inst.r.rs1),
		.rs2    (inst.r.rs2),
		.wb     (wb),
		.src1   (src1),
		.src2   (src2)
	);

	// ------------------------------------------------
	// immediates by format
	// ------------------------------------------------
	assign imm_i = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
	assign imm_s = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
	assign imm_b = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
		inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
	assign imm_u = {inst.u.imm_31_12, 12'b0};
	assign imm_j = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
		inst.j.imm_11, inst.j.imm_10_1, 1'b0};

	// ------------------------------------------------
	// field decode
	// ------------------------------------------------
	always_comb begin
		dec_d          = '0;
		dec_d.src1     = src1;
		dec_d.src2     = src2;
		dec_d.pc       = fetch_pkt.pc;
		dec_d.pc4      = fetch_pkt.pc4;
		dec_d.rd       = inst.r.rd;
		dec_d.alu_op   = alu_add;
		dec_d.b_sel    = src_rs2;
		dec_d.wb_sel   = wb_none;
		dec_d.br_cnd   = br_eq;
		dec_d.mem_size = mem_size_e'(inst.i.funct3[1:0]);
		case (opcode_e'(inst.r.opcode))
			opc_r: begin
				dec_d.wb_sel = wb_alu;
				dec_d.alu_op = alu_sel(inst.r.funct3, inst.r.funct7 == f7_alt, 1'b0);
				dec_d.ill    = !alu_ok(inst.r.funct3, inst.r.funct7, 1'b0);
			end
			opc_i_r: begin
				dec_d.wb_sel = wb_alu;
				dec_d.b_sel  = src_imm;
				dec_d.imm    = imm_i;
				dec_d.alu_op = alu_sel(inst.i.funct3, inst.r.funct7 == f7_alt, 1'b1);
				dec_d.ill    = !alu_ok(inst.i.funct3, inst.r.funct7, 1'b1);
			end
			opc_lui: begin
				dec_d.wb_sel = wb_imm;
				dec_d.imm    = imm_u;
			end
			opc_auipc, opc_jal: begin // alu forms pc+imm
				dec_d.wb_sel = (inst.r.opcode == opc_jal) ? wb_pc4 : wb_alu;
				dec_d.a_pc   = 1'b1;
				dec_d.b_sel  = src_imm;
				dec_d.imm    = (inst.r.opcode == opc_jal) ? imm_j : imm_u;
			end
			opc_jalr: begin
				dec_d.wb_sel = wb_pc4;
				dec_d.b_sel  = src_imm;
				dec_d.imm    = imm_i;
				dec_d.ill    = (inst.i.funct3 != 3'b000);
			end
			opc_branch: begin
				dec_d.br  = 1'b1;
				dec_d.imm = imm_b;
				case (inst.b.funct3)
					f3_beq:  dec_d.br_cnd = br_eq;
					f3_bne:  dec_d.br_cnd = br_ne;
					f3_blt:  dec_d.br_cnd = br_lt;
					f3_bltu: dec_d.br_cnd = br_ltu;
					f3_bge: begin
						dec_d.br_cnd = br_lt;
						dec_d.order  = 1'b1;
					end
					f3_bgeu: begin
						dec_d.br_cnd = br_ltu;
						dec_d.order  = 1'b1;
					end
					default: dec_d.ill = 1'b1;
				endcase
			end
			opc_load: begin // lb lh lw lbu lhu
				dec_d.mem_req = 1'b1;
				dec_d.imm     = imm_i;
				dec_d.ill     = (inst.i.funct3[1:0] == 2'b11) || (inst.i.funct3[2:1] == 2'b11);
			end
			opc_store: begin
				dec_d.mem_req = 1'b1;
				dec_d.mem_we  = 1'b1;
				dec_d.imm     = imm_s;
				dec_d.ill     = inst.s.funct3[2] || (inst.s.funct3[1:0] == 2'b11);
			end
			default: dec_d.ill = 1'b1;
		endcase
		// illegal words carry no side effects downstream
		if (dec_d.ill) begin
			dec_d.wb_sel  = wb_none;
			dec_d.br      = 1'b0;
			dec_d.mem_req = 1'b0;
			dec_d.mem_we  = 1'b0;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dec_val <= 1'b0;
		end else begin
			dec_val <= fetch_val & ~kill;
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_val) begin
			dec_pkt <= dec_d;
		end
	end

	// a store reaching execute never also asks for a register write
	a_store_no_wb: assert property (@(posedge clk) disable iff (!arst_n)
		(dec_val && dec_pkt.mem_we) |-> (dec_pkt.mem_req && dec_pkt.wb_sel == wb_none));

endmodule

//--- src/core_exe_s.sv
// no data memory behind the request; loads report it and write back nothing
`timescale 1ns/1ps

module core_exe_s (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               dec_val,
	input  core_pkg::dec_pkt_t dec_pkt,
	output logic               res_val,
	output core_pkg::exe_res_t res,
	output core_pkg::wb_t      wb
);
	import core_pkg::*;

	logic [xlen-1:0] op_a, op_b, alu_res;
	logic [4:0]      shamt;
	logic            cmp, taken, jump;
	logic [xlen-1:0] wb_data;
	exe_res_t        res_d;

	assign op_a  = dec_pkt.a_pc ? dec_pkt.pc : dec_pkt.src1;
	assign op_b  = (dec_pkt.b_sel == src_imm) ? dec_pkt.imm : dec_pkt.src2;
	assign shamt = op_b[4:0]; // upper shift bits ignored

	always_comb begin
		case (dec_pkt.alu_op)
			alu_add:  alu_res = op_a + op_b;
			alu_sub:  alu_res = op_a - op_b;
			alu_slt:  alu_res = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			alu_sltu: alu_res = {{(xlen-1){1'b0}}, op_a < op_b};
			alu_and:  alu_res = op_a & op_b;
			alu_or:   alu_res = op_a | op_b;
			alu_xor:  alu_res = op_a ^ op_b;
			alu_sll:  alu_res = op_a << shamt;
			alu_srl:  alu_res = op_a >> shamt;
			alu_sra:  alu_res = $unsigned($signed(op_a) >>> shamt);
			default:  alu_res = op_a + op_b;
		endcase
	end

	// ------------------------------------------------
	// branch compare, ge comes from an inverted lt
	// ------------------------------------------------
	always_comb begin
		case (dec_pkt.br_cnd)
			br_eq:   cmp = (dec_pkt.src1 == dec_pkt.src2);
			br_ne:   cmp = (dec_pkt.src1 != dec_pkt.src2);
			br_lt:   cmp = ($signed(dec_pkt.src1) < $signed(dec_pkt.src2));
			default: cmp = (dec_pkt.src1 < dec_pkt.src2);
		endcase
	end

	assign taken = dec_pkt.br & (cmp ^ dec_pkt.order);
	assign jump  = (dec_pkt.wb_sel == wb_pc4); // jal and jalr only

	always_comb begin
		case (dec_pkt.wb_sel)
			wb_alu:  wb_data = alu_res;
			wb_imm:  wb_data = dec_pkt.imm;
			wb_pc4:  wb_data = dec_pkt.pc4;
			default: wb_data = '0;
		endcase
	end

	always_comb begin
		res_d.rd        = dec_pkt.rd;
		res_d.data      = wb_data;
		res_d.we        = dec_val & ~dec_pkt.ill & (dec_pkt.wb_sel != wb_none) &
			(dec_pkt.rd != 5'd0);
		res_d.br_taken  = taken | jump;
		// jal already even, jalr needs bit 0 cleared
		res_d.target    = jump ? {alu_res[xlen-1:1], 1'b0} : dec_pkt.pc + dec_pkt.imm;
		res_d.mem_req   = dec_pkt.mem_req;
		res_d.mem_we    = dec_pkt.mem_we;
		res_d.mem_size  = dec_pkt.mem_size;
		res_d.mem_addr  = dec_pkt.src1 + dec_pkt.imm;
		res_d.mem_wdata = dec_pkt.mem_we ? dec_pkt.src2 : '0;
		res_d.ill       = dec_pkt.ill;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			res_val <= 1'b0;
			res     <= '0;
		end else begin
			res_val <= dec_val;
			res     <= res_d;
		end
	end

	assign wb = '{we: res.we, rd: res.rd, data: res.data}; // same register as res

	a_res_has_src: assert property (@(posedge clk) disable iff (!arst_n)
		(res_val || wb.we) |-> $past(dec_val));

endmodule

//--- src/core_fetch_s.sv
// pc advances on every strobe, killed ones included; the pc is never redirected
`timescale 1ns/1ps

module core_fetch_s #(
	parameter logic [core_pkg::xlen-1:0] reset_pc = 32'h0000_0000
) (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      inst_val,
	input  logic [core_pkg::xlen-1:0] inst,
	input  logic                      kill,
	output logic                      fetch_val,
	output core_pkg::fetch_pkt_t      fetch_pkt
);
	import core_pkg::*;

	logic [xlen-1:0] pc;
	logic [xlen-1:0] pc4;

	assign pc4 = pc + xlen'(4);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc        <= reset_pc;
			fetch_val <= 1'b0;
		end else begin
			fetch_val <= inst_val & ~kill; // flush drops the pending strobe
			if (inst_val) begin
				pc <= pc4;
			end
		end
	end

	// payload only, qualified by fetch_val downstream
	always_ff @(posedge clk) begin
		if (inst_val) begin
			fetch_pkt.inst <= inst;
			fetch_pkt.pc   <= pc;
			fetch_pkt.pc4  <= pc4;
		end
	end

	a_inst_known: assert property (@(posedge clk) disable iff (!arst_n)
		inst_val |-> !$isunknown(inst));

endmodule

//--- src/core_pkg.sv
// rv32i base subset only: no fence, csr, ecall or compressed forms, xlen fixed at 32
package core_pkg;

	localparam int xlen = 32;

	// ------------------------------------------------
	// major opcodes and function codes
	// ------------------------------------------------
	typedef enum logic [6:0] {
		opc_r      = 7'b0110011,
		opc_i_r    = 7'b0010011,
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_branch = 7'b1100011,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011
	} opcode_e;

	localparam logic [2:0] f3_add  = 3'b000; // add, sub, addi
	localparam logic [2:0] f3_sll  = 3'b001;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	localparam logic [2:0] f3_srl  = 3'b101; // srl and sra
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;

	localparam logic [2:0] f3_beq  = 3'b000;
	localparam logic [2:0] f3_bne  = 3'b001;
	localparam logic [2:0] f3_blt  = 3'b100;
	localparam logic [2:0] f3_bge  = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_alt  = 7'b0100000; // sub, sra

	// ------------------------------------------------
	// control encodings
	// ------------------------------------------------
	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_slt, alu_sltu, alu_and,
		alu_or, alu_xor, alu_sll, alu_srl, alu_sra
	} alu_op_e;

	typedef enum logic [1:0] {br_eq, br_ne, br_lt, br_ltu} br_cnd_e;
	// same values as funct3[1:0] of loads and stores
	typedef enum logic [1:0] {mem_byte = 2'd0, mem_half = 2'd1, mem_word = 2'd2} mem_size_e;
	typedef enum logic [1:0] {src_rs2, src_imm} src_sel_e;
	typedef enum logic [1:0] {wb_alu, wb_imm, wb_pc4, wb_none} wb_sel_e;

	// ------------------------------------------------
	// instruction formats, msb first
	// ------------------------------------------------
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2, rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2, rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2, rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} inst_u;

	// ------------------------------------------------
	// stage packets
	// ------------------------------------------------
	typedef struct packed {
		inst_u           inst;
		logic [xlen-1:0] pc, pc4;
	} fetch_pkt_t;

	typedef struct packed {
		logic [xlen-1:0] src1, src2, imm, pc, pc4;
		logic [4:0]      rd;
		alu_op_e         alu_op;
		logic            a_pc;      // pc as alu operand a
		src_sel_e        b_sel;
		wb_sel_e         wb_sel;
		logic            br;
		br_cnd_e         br_cnd;
		logic            order;     // inverts lt/ltu into ge/geu
		logic            mem_req, mem_we;
		mem_size_e       mem_size;
		logic            ill;
	} dec_pkt_t;

	typedef struct packed {
		logic            we;
		logic [4:0]      rd;
		logic [xlen-1:0] data;
	} wb_t;

	typedef struct packed {
		logic [4:0]      rd;
		logic [xlen-1:0] data;
		logic            we;
		logic            br_taken;
		logic [xlen-1:0] target;
		logic            mem_req, mem_we;
		mem_size_e       mem_size;
		logic [xlen-1:0] mem_addr, mem_wdata;
		logic            ill;
	} exe_res_t;

endpackage

//--- src/core_reg_file.sv
// reads are combinational; a write lands on the edge and is not bypassed to a same-cycle read
`timescale 1ns/1ps

module core_reg_file (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic [4:0]                rs1,
	input  logic [4:0]                rs2,
	input  core_pkg::wb_t             wb,
	output logic [core_pkg::xlen-1:0] src1,
	output logic [core_pkg::xlen-1:0] src2
);
	import core_pkg::*;

	logic [xlen-1:0] regs [32]; // x0 kept at zero by the write guard

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int k = 0; k < 32; k++) begin
				regs[k] <= '0;
			end
		end else if (wb.we && wb.rd != 5'd0) begin
			regs[wb.rd] <= wb.data;
		end
	end

	assign src1 = regs[rs1];
	assign src2 = regs[rs2];

	// x0 stays zero on both ports, also after a write aimed at it
	a_x0_reads_zero: assert property (@(posedge clk) disable iff (!arst_n)
		((rs1 == 5'd0) |-> (src1 == '0)) and ((rs2 == 5'd0) |-> (src2 == '0)));

endmodule

//--- src/core_top.sv
// one instruction per strobe with no back-pressure; register hazards are left to the issuer
`timescale 1ns/1ps

module core_top #(
	parameter logic [core_pkg::xlen-1:0] reset_pc = 32'h0000_0000
) (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      inst_val,
	input  logic [core_pkg::xlen-1:0] inst,
	input  logic                      kill,
	output logic                      res_val,
	output core_pkg::exe_res_t        res
);
	import core_pkg::*;

	logic       fetch_val;
	fetch_pkt_t fetch_pkt;
	logic       dec_val;
	dec_pkt_t   dec_pkt;
	wb_t        wb;        // execute back to the decode register file

	// ------------------------------------------------
	// fetch -> decode -> execute
	// ------------------------------------------------
	core_fetch_s #(
		.reset_pc (reset_pc)
	) u_fetch (
		.clk       (clk),
		.arst_n    (arst_n),
		.inst_val  (inst_val),
		.inst      (inst),
		.kill      (kill),
		.fetch_val (fetch_val),
		.fetch_pkt (fetch_pkt)
	);

	core_dec_s u_dec (
		.clk       (clk),
		.arst_n    (arst_n),
		.fetch_val (fetch_val),
		.fetch_pkt (fetch_pkt),
		.kill      (kill),
		.wb        (wb),
		.dec_val   (dec_val),
		.dec_pkt   (dec_pkt)
	);

	core_exe_s u_exe (
		.clk     (clk),
		.arst_n  (arst_n),
		.dec_val (dec_val),
		.dec_pkt (dec_pkt),
		.res_val (res_val),
		.res     (res),
		.wb      (wb)
	);

endmodule

//--- vlog.f
src/core_pkg.sv
src/core_fetch_s.sv
src/core_reg_file.sv
src/core_dec_s.sv
src/core_exe_s.sv
src/core_top.sv
dv/core_tb.sv
